// File: verilog/rv_pkg.sv
package rv_pkg;

    // ----------------------------------------
    // widths and memory depths
    // ----------------------------------------
    localparam int XLEN       = 32; // data and instruction width
    localparam int REG_AW     = 5;  // register address width
    localparam int IMEM_DEPTH = 64; // instruction memory words
    localparam int IMEM_AW    = 6;  // instruction memory word address
    localparam int DMEM_DEPTH = 32; // data memory words
    localparam int DMEM_AW    = 5;  // data memory word address

    // ----------------------------------------
    // common types
    // ----------------------------------------
    typedef logic [XLEN-1:0]   word_t;     // one machine word
    typedef logic [REG_AW-1:0] reg_addr_t; // x0 .. x31
    typedef logic [6:0]        opcode_t;   // instr[6:0]
    typedef logic [2:0]        funct3_t;   // instr[14:12]

    // ----------------------------------------
    // major opcodes
    // ----------------------------------------
    localparam opcode_t OPC_OP     = 7'b0110011; // add sub and or xor
    localparam opcode_t OPC_OP_IMM = 7'b0010011; // addi only
    localparam opcode_t OPC_LOAD   = 7'b0000011; // lw only
    localparam opcode_t OPC_STORE  = 7'b0100011; // sw only

    // ----------------------------------------
    // funct3 codes
    // ----------------------------------------
    localparam funct3_t F3_ADD_SUB = 3'b000; // funct7 bit 5 picks sub
    localparam funct3_t F3_XOR     = 3'b100;
    localparam funct3_t F3_OR      = 3'b110;
    localparam funct3_t F3_AND     = 3'b111;
    localparam funct3_t F3_LW_SW   = 3'b010; // word access for lw and sw

endpackage

// File: verilog/decode_if.sv
`timescale 1ns/1ps

// decoded instruction bundle, decode stage to execute stage
interface decode_if;
    import rv_pkg::*;

    logic      valid;      // one strobe per instruction
    opcode_t   opcode;     // registered instr[6:0]
    funct3_t   funct3;     // registered instr[14:12]
    logic      funct7_5;   // registered instr[30]
    reg_addr_t rd;         // destination register
    word_t     offset;     // sign-extended I or S immediate
    word_t     read_data1; // rf read at registered rs1
    word_t     read_data2; // rf read at registered rs2

    modport decode (
        output valid,
        output opcode,
        output funct3,
        output funct7_5,
        output rd,
        output offset,
        output read_data1,
        output read_data2
    );

    modport execute (
        input valid,
        input opcode,
        input funct3,
        input funct7_5,
        input rd,
        input offset,
        input read_data1,
        input read_data2
    );

endinterface

// File: verilog/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage (
    input  logic                       clk,
    input  logic                       reset_i,
    input  logic                       run_i,        // issue enable
    input  logic                       imem_we_i,    // program load strobe
    input  logic [rv_pkg::IMEM_AW-1:0] imem_addr_i,  // word address
    input  rv_pkg::word_t              imem_wdata_i, // instruction to load
    output logic                       f_valid_o,    // fetched strobe
    output rv_pkg::word_t              f_instr_o     // fetched instruction
);
    import rv_pkg::*;

    // ----------------------------------------
    // storage
    // ----------------------------------------
    word_t              imem [IMEM_DEPTH]; // instruction memory
    logic [IMEM_AW+1:0] pc_q;              // byte pc, wraps with its width
    logic [IMEM_AW-1:0] pc_word;           // word index into imem

    assign pc_word = pc_q[IMEM_AW+1:2]; // drop byte offset

    // ----------------------------------------
    // load port
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (imem_we_i) begin
            imem[imem_addr_i] <= imem_wdata_i; // testbench fills program
        end
    end

    // ----------------------------------------
    // program counter and valid
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_q      <= '0;   // start at word 0
            f_valid_o <= 1'b0;
        end else begin
            f_valid_o <= run_i; // one strobe per issued word
            if (run_i) begin
                pc_q <= pc_q + (IMEM_AW+2)'(4); // next word, wraps at 64
            end
        end
    end

    // fetch output register
    always_ff @(posedge clk) begin
        if (run_i) begin
            f_instr_o <= imem[pc_word]; // holds while paused
        end
    end

endmodule

// File: verilog/pipeline_decode.sv
`timescale 1ns/1ps

module pipeline_decode (
    input  logic              clk,
    input  logic              reset_i,
    input  logic              f_valid_i,    // fetched strobe
    input  rv_pkg::word_t     f_instr_i,    // fetched instruction
    input  logic              reg_write_i,  // write-back enable
    input  rv_pkg::reg_addr_t write_reg_i,  // write-back register
    input  rv_pkg::word_t     write_data_i, // write-back value
    decode_if.decode          dec           // to execute
);
    import rv_pkg::*;

    // ----------------------------------------
    // field registers
    // ----------------------------------------
    logic      valid_q;    // decode stage occupied
    opcode_t   opcode_q;
    funct3_t   funct3_q;
    logic      funct7_5_q; // sub select
    reg_addr_t rs1_q;
    reg_addr_t rs2_q;
    reg_addr_t rd_q;
    word_t     offset_q;   // sign-extended immediate

    word_t     imm_i;      // I-type immediate of incoming word
    word_t     imm_s;      // S-type immediate of incoming word
    word_t     regs [2**REG_AW]; // register file

    assign imm_i = {{(XLEN-12){f_instr_i[31]}}, f_instr_i[31:20]};
    assign imm_s = {{(XLEN-12){f_instr_i[31]}}, f_instr_i[31:25], f_instr_i[11:7]};

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= f_valid_i; // strobe moves one stage
        end
    end

    always_ff @(posedge clk) begin
        if (f_valid_i) begin
            opcode_q   <= f_instr_i[6:0];
            funct3_q   <= f_instr_i[14:12];
            funct7_5_q <= f_instr_i[30];
            rs1_q      <= f_instr_i[19:15]; // rs1 field
            rs2_q      <= f_instr_i[24:20]; // rs2 field
            rd_q       <= f_instr_i[11:7];
            if (f_instr_i[6:0] == OPC_STORE) begin
                offset_q <= imm_s; // split immediate for sw
            end else begin
                offset_q <= imm_i; // addi and lw
            end
        end
    end

    // ----------------------------------------
    // register file
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < 2**REG_AW; i++) begin
                regs[i] <= '0; // all of x0 .. x31
            end
        end else if (reg_write_i && (write_reg_i != '0)) begin
            regs[write_reg_i] <= write_data_i; // x0 stays zero
        end
    end

    // ----------------------------------------
    // outputs to execute
    // ----------------------------------------
    assign dec.valid      = valid_q;
    assign dec.opcode     = opcode_q;
    assign dec.funct3     = funct3_q;
    assign dec.funct7_5   = funct7_5_q;
    assign dec.rd         = rd_q;
    assign dec.offset     = offset_q;
    assign dec.read_data1 = (rs1_q == '0) ? '0 : regs[rs1_q]; // async read
    assign dec.read_data2 = (rs2_q == '0) ? '0 : regs[rs2_q]; // async read

endmodule

// File: verilog/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  logic              clk,
    input  logic              reset_i,
    decode_if.execute         dec,           // from decode
    output logic              reg_write_o,   // write-back enable, this cycle
    output rv_pkg::reg_addr_t write_reg_o,   // write-back register
    output rv_pkg::word_t     write_data_o,  // write-back value
    output logic              wb_valid_o,    // retire strobe
    output rv_pkg::reg_addr_t wb_rd_o,       // retired rd
    output rv_pkg::word_t     wb_data_o,     // retired value
    output logic              store_valid_o, // store strobe
    output rv_pkg::word_t     store_addr_o,  // byte address of store
    output rv_pkg::word_t     store_data_o   // stored word
);
    import rv_pkg::*;

    // ----------------------------------------
    // datapath signals
    // ----------------------------------------
    word_t              addr;       // rs1 + offset
    logic [DMEM_AW-1:0] dmem_idx;   // word index into dmem
    word_t              result;     // value to retire
    logic               is_retire;  // supported rd-writing instruction
    logic               is_store;   // supported sw
    logic               store_now;  // qualified store
    word_t              dmem [DMEM_DEPTH]; // data memory

    assign addr     = dec.read_data1 + dec.offset; // also the addi sum
    assign dmem_idx = addr[DMEM_AW+1:2];           // address bits 6:2

    // operation select
    always_comb begin
        result    = '0;
        is_retire = 1'b0;
        is_store  = 1'b0;
        case (dec.opcode)
            OPC_OP: begin
                is_retire = 1'b1;
                case (dec.funct3)
                    F3_ADD_SUB: result = dec.funct7_5 ? dec.read_data1 - dec.read_data2
                                                      : dec.read_data1 + dec.read_data2;
                    F3_XOR:     result = dec.read_data1 ^ dec.read_data2;
                    F3_OR:      result = dec.read_data1 | dec.read_data2;
                    F3_AND:     result = dec.read_data1 & dec.read_data2;
                    default:    is_retire = 1'b0; // unsupported funct3
                endcase
            end
            OPC_OP_IMM: begin
                if (dec.funct3 == F3_ADD_SUB) begin
                    is_retire = 1'b1;
                    result    = addr; // addi
                end
            end
            OPC_LOAD: begin
                if (dec.funct3 == F3_LW_SW) begin
                    is_retire = 1'b1;
                    result    = dmem[dmem_idx]; // lw, async read
                end
            end
            OPC_STORE: begin
                is_store = (dec.funct3 == F3_LW_SW); // sw only
            end
            default: begin
                is_retire = 1'b0; // anything else drops out
            end
        endcase
    end

    assign store_now = dec.valid & is_store;

    // ----------------------------------------
    // write-back into decode
    // ----------------------------------------
    // written at the edge that ends execute, so the next
    // instruction reads the new value without forwarding
    assign reg_write_o  = dec.valid & is_retire;
    assign write_reg_o  = dec.rd;  // rd 0 ignored by the rf
    assign write_data_o = result;

    // data memory
    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < DMEM_DEPTH; i++) begin
                dmem[i] <= '0;
            end
        end else if (store_now) begin
            dmem[dmem_idx] <= dec.read_data2; // sw data from rs2
        end
    end

    // ----------------------------------------
    // retire and store outputs
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (reset_i) begin
            wb_valid_o    <= 1'b0;
            store_valid_o <= 1'b0;
        end else begin
            wb_valid_o    <= reg_write_o; // never both high
            store_valid_o <= store_now;
        end
    end

    always_ff @(posedge clk) begin
        if (reg_write_o) begin
            wb_rd_o   <= dec.rd;
            wb_data_o <= result;
        end
        if (store_now) begin
            store_addr_o <= addr;           // full byte address
            store_data_o <= dec.read_data2;
        end
    end

endmodule

// File: verilog/rv_core_top.sv
`timescale 1ns/1ps

module rv_core_top (
    input  logic                       clk,
    input  logic                       reset_i,
    input  logic                       imem_we_i,     // program load strobe
    input  logic [rv_pkg::IMEM_AW-1:0] imem_addr_i,   // program word address
    input  rv_pkg::word_t              imem_wdata_i,  // program word
    input  logic                       run_i,         // issue enable
    output logic                       wb_valid_o,    // retire strobe
    output rv_pkg::reg_addr_t          wb_rd_o,       // retired rd
    output rv_pkg::word_t              wb_data_o,     // retired value
    output logic                       store_valid_o, // store strobe
    output rv_pkg::word_t              store_addr_o,  // store byte address
    output rv_pkg::word_t              store_data_o   // stored word
);
    import rv_pkg::*;

    // ----------------------------------------
    // stage to stage wiring
    // ----------------------------------------
    logic      f_valid;      // fetch -> decode
    word_t     f_instr;
    logic      wb_reg_write; // execute -> decode rf write
    reg_addr_t wb_rd;
    word_t     wb_data;

    decode_if dec_bus ();    // decode -> execute

    fetch_stage u_fetch (
        .clk          (clk),
        .reset_i      (reset_i),
        .run_i        (run_i),
        .imem_we_i    (imem_we_i),
        .imem_addr_i  (imem_addr_i),
        .imem_wdata_i (imem_wdata_i),
        .f_valid_o    (f_valid),
        .f_instr_o    (f_instr)
    );

    pipeline_decode u_decode (
        .clk          (clk),
        .reset_i      (reset_i),
        .f_valid_i    (f_valid),
        .f_instr_i    (f_instr),
        .reg_write_i  (wb_reg_write),
        .write_reg_i  (wb_rd),
        .write_data_i (wb_data),
        .dec          (dec_bus.decode)
    );

    execute_stage u_execute (
        .clk           (clk),
        .reset_i       (reset_i),
        .dec           (dec_bus.execute),
        .reg_write_o   (wb_reg_write),
        .write_reg_o   (wb_rd),
        .write_data_o  (wb_data),
        .wb_valid_o    (wb_valid_o),
        .wb_rd_o       (wb_rd_o),
        .wb_data_o     (wb_data_o),
        .store_valid_o (store_valid_o),
        .store_addr_o  (store_addr_o),
        .store_data_o  (store_data_o)
    );

endmodule

// File: verif/rv_core_properties.sv
`timescale 1ns/1ps

module rv_core_properties (
    input logic clk,
    input logic reset_i,
    input logic run_i,
    input logic wb_valid_o,
    input logic store_valid_o
);

    // ----------------------------------------
    // output strobe rules
    // ----------------------------------------
    // one instruction retires or stores, never both
    strobes_exclusive: assert property (
        @(posedge clk) disable iff (reset_i)
        !(wb_valid_o && store_valid_o)
    ) else $error("retire and store strobes high together");

    strobes_cleared_by_reset: assert property (
        @(posedge clk)
        reset_i |=> (!wb_valid_o && !store_valid_o) // registered clear
    ) else $error("output strobe high one cycle after reset");

    // three edges from run_i to any strobe
    no_strobe_after_release: assert property (
        @(posedge clk)
        ($fell(reset_i) && !run_i) |-> (!wb_valid_o && !store_valid_o) [*3]
    ) else $error("output strobe soon after reset release without run_i");

endmodule

bind rv_core_top rv_core_properties u_props (
    .clk           (clk),
    .reset_i       (reset_i),
    .run_i         (run_i),
    .wb_valid_o    (wb_valid_o),
    .store_valid_o (store_valid_o)
);

// File: verif/rv_core_tb.sv
`timescale 1ns/1ps

module rv_core_tb;
    import rv_pkg::*;

    typedef enum logic [1:0] {KIND_NONE, KIND_RETIRE, KIND_STORE} kind_t;
    typedef struct packed {
        kind_t     kind;
        reg_addr_t rd;
        word_t     data; // retired value or stored word
        word_t     addr; // store byte address
    } exp_t;
    typedef logic [31:0][XLEN-1:0] bank_t; // 32 words, packed

    logic              clk;
    logic              reset_i;
    logic              imem_we_i;
    logic [IMEM_AW-1:0] imem_addr_i;
    word_t             imem_wdata_i;
    logic              run_i;
    logic              wb_valid_o;
    reg_addr_t         wb_rd_o;
    word_t             wb_data_o;
    logic              store_valid_o;
    word_t             store_addr_o;
    word_t             store_data_o;

    word_t  prog [$];        // program being built
    exp_t   exp_q [$];       // expected results, in order
    bank_t  model_regs;      // reference register file
    bank_t  model_mem;       // reference data memory
    logic [31:0] lfsr_q;     // random source state
    int     pc_idx;          // fetch word index tracked by the testbench
    int     checked;         // results compared so far
    int     total;           // results expected so far

    rv_core_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk; // 20 ns period
    end

    // ----------------------------------------
    // failure reporting and compares
    // ----------------------------------------
    task automatic stop_on_error();
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic check_reg(input string name, input reg_addr_t got, input reg_addr_t exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
            stop_on_error();
        end
    endtask

    // ----------------------------------------
    // random bits and encoders
    // ----------------------------------------
    function automatic word_t lfsr_bits(input int n);
        word_t r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 32'h8020_0003) : (lfsr_q >> 1); // galois step
            r = {r[XLEN-2:0], lfsr_q[0]}; // one bit per step
        end
        return r;
    endfunction

    function automatic word_t enc_r(input logic f7_5, input reg_addr_t rs2, input reg_addr_t rs1,
                                    input funct3_t f3, input reg_addr_t rd);
        return {1'b0, f7_5, 5'b0, rs2, rs1, f3, rd, OPC_OP};
    endfunction

    function automatic word_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                    input funct3_t f3, input reg_addr_t rd, input opcode_t opc);
        return {imm, rs1, f3, rd, opc};
    endfunction

    function automatic word_t enc_s(input logic [11:0] imm, input reg_addr_t rs2,
                                    input reg_addr_t rs1);
        return {imm[11:5], rs2, rs1, F3_LW_SW, imm[4:0], OPC_STORE};
    endfunction

    function automatic word_t random_instr();
        logic [2:0]  sel;
        reg_addr_t   rd;
        reg_addr_t   rs1;
        reg_addr_t   rs2;
        logic [11:0] imm;
        logic [4:0]  widx; // word index for lw and sw
        sel  = 3'(lfsr_bits(3));
        rd   = 5'(lfsr_bits(5));
        rs1  = 5'(lfsr_bits(5));
        rs2  = 5'(lfsr_bits(5));
        imm  = 12'(lfsr_bits(12));
        widx = 5'(lfsr_bits(5));
        case (sel)
            3'd0:    return enc_r(1'b0, rs2, rs1, F3_ADD_SUB, rd);
            3'd1:    return enc_r(1'b1, rs2, rs1, F3_ADD_SUB, rd); // sub
            3'd2:    return enc_r(1'b0, rs2, rs1, F3_AND, rd);
            3'd3:    return enc_r(1'b0, rs2, rs1, F3_OR, rd);
            3'd4:    return enc_r(1'b0, rs2, rs1, F3_XOR, rd);
            3'd5:    return enc_i(imm, rs1, F3_ADD_SUB, rd, OPC_OP_IMM);
            3'd6:    return enc_i({5'b0, widx, 2'b00}, 5'd0, F3_LW_SW, rd, OPC_LOAD); // x0 base
            default: return enc_s({5'b0, widx, 2'b00}, rs2, 5'd0);
        endcase
    endfunction

    // ----------------------------------------
    // reference model, one instruction
    // ----------------------------------------
    function automatic exp_t ref_exec(input word_t instr, input bank_t regs, input bank_t mem);
        exp_t  e;
        word_t a;
        word_t b;
        word_t imm_i;
        word_t imm_s;
        e      = '0;
        e.rd   = instr[11:7];
        a      = regs[instr[19:15]]; // x0 held at zero by the caller
        b      = regs[instr[24:20]];
        imm_i  = {{20{instr[31]}}, instr[31:20]};
        imm_s  = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        e.kind = KIND_RETIRE;
        case (instr[6:0])
            OPC_OP: begin
                case (instr[14:12])
                    F3_ADD_SUB: e.data = instr[30] ? a - b : a + b;
                    F3_XOR:     e.data = a ^ b;
                    F3_OR:      e.data = a | b;
                    F3_AND:     e.data = a & b;
                    default:    e.kind = KIND_NONE;
                endcase
            end
            OPC_OP_IMM: begin
                if (instr[14:12] == F3_ADD_SUB) e.data = a + imm_i;
                else e.kind = KIND_NONE;
            end
            OPC_LOAD: begin
                e.addr = a + imm_i;
                if (instr[14:12] == F3_LW_SW) e.data = mem[e.addr[DMEM_AW+1:2]];
                else e.kind = KIND_NONE;
            end
            OPC_STORE: begin
                e.addr = a + imm_s;
                e.data = b;
                e.kind = (instr[14:12] == F3_LW_SW) ? KIND_STORE : KIND_NONE;
            end
            default: e.kind = KIND_NONE; // unsupported opcode
        endcase
        return e;
    endfunction

    // ----------------------------------------
    // program load, run and drain
    // ----------------------------------------
    task automatic run_prog();
        exp_t e;
        int   n;
        n = prog.size();
        for (int k = 0; k < n; k++) begin
            @(negedge clk);
            imem_we_i    = 1'b1;
            imem_addr_i  = IMEM_AW'((pc_idx + k) % IMEM_DEPTH); // continue at current pc
            imem_wdata_i = prog[k];
        end
        for (int k = 0; k < n; k++) begin
            e = ref_exec(prog[k], model_regs, model_mem);
            if (e.kind == KIND_RETIRE && e.rd != '0) model_regs[e.rd] = e.data;
            if (e.kind == KIND_STORE) model_mem[e.addr[DMEM_AW+1:2]] = e.data;
            if (e.kind != KIND_NONE) begin
                exp_q.push_back(e);
                total++;
            end
        end
        @(negedge clk);
        imem_we_i = 1'b0;
        run_i     = 1'b1;
        repeat (n) @(negedge clk); // n issue edges
        run_i  = 1'b0;
        pc_idx = (pc_idx + n) % IMEM_DEPTH;
        prog.delete();
    endtask

    task automatic wait_drain();
        int cnt;
        cnt = 0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
            cnt++;
            if (cnt > 40) begin
                $display("timeout: %0d expected results never appeared", exp_q.size());
                stop_on_error();
            end
        end
    endtask

    // ----------------------------------------
    // checker, outputs are stable at the falling edge
    // ----------------------------------------
    always @(negedge clk) begin : compare_results
        exp_t e;
        if (wb_valid_o === 1'b1 && store_valid_o === 1'b1) begin
            $display("retire and store strobes were high in the same cycle");
            stop_on_error();
        end else if (wb_valid_o === 1'b1 || store_valid_o === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("an output strobe appeared with no result pending");
                stop_on_error();
            end else begin
                e = exp_q.pop_front();
                if (wb_valid_o && e.kind != KIND_RETIRE) begin
                    $display("a retire appeared where a store was expected");
                    stop_on_error();
                end else if (store_valid_o && e.kind != KIND_STORE) begin
                    $display("a store appeared where a retire was expected");
                    stop_on_error();
                end else if (wb_valid_o) begin
                    check_reg("wb_rd_o", wb_rd_o, e.rd);
                    check_word("wb_data_o", wb_data_o, e.data);
                end else begin
                    check_word("store_addr_o", store_addr_o, e.addr);
                    check_word("store_data_o", store_data_o, e.data);
                end
                checked++;
            end
        end
    end

    // ----------------------------------------
    // stimulus
    // ----------------------------------------
    initial begin
        reset_i = 1'b1;
        run_i = 1'b0;
        imem_we_i = 1'b0;
        imem_addr_i = '0;
        imem_wdata_i = '0;
        lfsr_q = 32'h427b;
        model_regs = '0;
        model_mem = '0;
        pc_idx = 0;
        checked = 0;
        total = 0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;
        repeat (10) @(negedge clk); // idle, any strobe is flagged

        for (int r = 1; r <= 5; r++) begin // addi x1..x5 from x0
            prog.push_back(enc_i(12'(r * 700 - 1900), 5'd0, F3_ADD_SUB, 5'(r), OPC_OP_IMM));
        end
        run_prog();
        wait_drain();

        prog.push_back(enc_r(1'b0, 5'd2, 5'd1, F3_ADD_SUB, 5'd6)); // chain, each feeds next
        prog.push_back(enc_r(1'b1, 5'd3, 5'd6, F3_ADD_SUB, 5'd7));
        prog.push_back(enc_r(1'b0, 5'd4, 5'd7, F3_AND, 5'd8));
        prog.push_back(enc_r(1'b0, 5'd5, 5'd8, F3_OR, 5'd9));
        prog.push_back(enc_r(1'b0, 5'd1, 5'd9, F3_XOR, 5'd10));
        prog.push_back(enc_r(1'b1, 5'd10, 5'd10, F3_ADD_SUB, 5'd10)); // self sub, zero
        prog.push_back(enc_s(12'd40, 5'd3, 5'd0));                    // sw x3, 40(x0)
        prog.push_back(enc_s(12'd8, 5'd9, 5'd5));                     // base from x5
        prog.push_back(enc_i(12'd40, 5'd0, F3_LW_SW, 5'd11, OPC_LOAD));
        prog.push_back(enc_i(12'(model_regs[5] + 8), 5'd0, F3_LW_SW, 5'd12, OPC_LOAD));
        prog.push_back(enc_i(12'd77, 5'd0, F3_ADD_SUB, 5'd0, OPC_OP_IMM)); // write x0
        prog.push_back(enc_r(1'b0, 5'd0, 5'd0, F3_ADD_SUB, 5'd13));        // x0 reads zero
        prog.push_back(32'h0020_8063);                                      // branch, dropped
        prog.push_back(enc_r(1'b0, 5'd2, 5'd1, 3'b001, 5'd14));             // sll, dropped
        prog.push_back(enc_i(12'd3, 5'd1, 3'b001, 5'd15, OPC_OP_IMM));      // slli, dropped
        prog.push_back(enc_i(12'hfff, 5'd13, F3_ADD_SUB, 5'd16, OPC_OP_IMM));
        run_prog();
        wait_drain();

        for (int half = 0; half < 2; half++) begin
            for (int chunk = 0; chunk < 3; chunk++) begin
                for (int k = 0; k < 50; k++) prog.push_back(random_instr());
                run_prog();
            end
            wait_drain();
            repeat (8) @(negedge clk); // run_i paused, pipeline idle
        end

        wait_drain();
        repeat (10) @(negedge clk);
        if (exp_q.size() == 0 && checked == total) begin
            $display("TESTS PASSED");
            $finish;
        end else begin
            $display("%0d of %0d results were compared", checked, total);
            stop_on_error();
        end
    end

endmodule

// File: list.f
verilog/rv_pkg.sv
verilog/decode_if.sv
verilog/fetch_stage.sv
verilog/pipeline_decode.sv
verilog/execute_stage.sv
verilog/rv_core_top.sv
verif/rv_core_properties.sv
verif/rv_core_tb.sv

// File: Bender.yml
package:
  name: rv_core

sources:
  - verilog/rv_pkg.sv
  - verilog/decode_if.sv
  - verilog/fetch_stage.sv
  - verilog/pipeline_decode.sv
  - verilog/execute_stage.sv
  - verilog/rv_core_top.sv
  - target: test
    files:
      - verif/rv_core_properties.sv
      - verif/rv_core_tb.sv
